/* source/isa_pkg.sv */
`default_nettype none

package isa_pkg;

   // Major opcode, instr[15:11]
   typedef enum logic [4:0] {
      op_halt  = 5'b00000,
      op_nop   = 5'b00001,
      op_j     = 5'b00100,
      op_addi  = 5'b01000,
      op_xori  = 5'b01010,
      op_beqz  = 5'b01100,
      op_bnez  = 5'b01101,
      op_lbi   = 5'b11000,
      op_shift = 5'b11010,
      op_arith = 5'b11011
   } opcode_e;

   // Function codes, arith group
   localparam logic [1:0] func_add = 2'b00;
   localparam logic [1:0] func_sub = 2'b01;
   localparam logic [1:0] func_xor = 2'b10;
   localparam logic [1:0] func_and = 2'b11;

   // Function codes, shift group
   localparam logic [1:0] func_sll = 2'b00;
   localparam logic [1:0] func_srl = 2'b01;
   localparam logic [1:0] func_rol = 2'b10;
   localparam logic [1:0] func_ror = 2'b11;

   // Field positions
   localparam int opcode_msb = 15;
   localparam int opcode_lsb = 11;
   localparam int rs_msb     = 10;
   localparam int rs_lsb     = 8;
   localparam int rt_msb     = 7;
   localparam int rt_lsb     = 5;
   // R-format destination
   localparam int rd_r_msb   = 4;
   localparam int rd_r_lsb   = 2;
   localparam int func_msb   = 1;
   localparam int func_lsb   = 0;
   // I-format destination sits where rt is in R-format
   localparam int rd_i_msb   = 7;
   localparam int rd_i_lsb   = 5;
   localparam int imm5_msb   = 4;
   localparam int imm5_lsb   = 0;
   localparam int imm8_msb   = 7;
   localparam int imm8_lsb   = 0;
   localparam int imm11_msb  = 10;
   localparam int imm11_lsb  = 0;

endpackage

`default_nettype wire

/* source/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

   // Datapath width
   localparam int data_w = 16;

   // Instruction memory depth in words
   localparam int imem_words = 256;

   // Register index
   typedef logic [2:0] reg_idx_t;

   // ALU operations
   typedef enum logic [3:0] {
      alu_add,
      alu_sub,
      alu_xor,
      alu_and,
      alu_sll,
      alu_srl,
      alu_rol,
      alu_ror,
      alu_pass_b
   } alu_op_e;

   // Next-PC source
   typedef enum logic [1:0] {
      br_none,
      br_beqz,
      br_bnez,
      br_jump
   } branch_e;

   // Decoded control for one instruction
   typedef struct packed {
      alu_op_e  alu_op;
      reg_idx_t dest;
      logic     reg_we;
      branch_e  branch;
      logic     halt;
      logic     illegal;
   } ctrl_t;

   // Per-instruction retire record
   typedef struct packed {
      logic              valid;
      logic [data_w-1:0] pc;
      logic              reg_we;
      reg_idx_t          dest;
      logic [data_w-1:0] data;
   } commit_t;

endpackage

`default_nettype wire

/* source/instr_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module instr_mem (
   input  wire logic                       clk,
   input  wire logic [cpu_pkg::data_w-1:0] addr,
   output logic      [cpu_pkg::data_w-1:0] instr,
   input  wire logic                       load_we,
   input  wire logic [7:0]                 load_addr,
   input  wire logic [cpu_pkg::data_w-1:0] load_data
);

   localparam int aw = $clog2(cpu_pkg::imem_words);

   // Program storage, contents come only from the load port
   logic [cpu_pkg::data_w-1:0] mem [cpu_pkg::imem_words];

   // Byte address in, word index is addr[aw:1]
   assign instr = mem[addr[aw:1]];

   // Load port, only active while the core is held in reset
   always_ff @(posedge clk) begin
      if (load_we) begin
         mem[load_addr[aw-1:0]] <= load_data;
      end
   end

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
   input  wire logic                       clk,
   input  wire logic                       rst,
   input  wire logic                       hold,
   input  wire cpu_pkg::branch_e           branch,
   input  wire logic                       zero,
   input  wire logic [cpu_pkg::data_w-1:0] instr,
   output logic      [cpu_pkg::data_w-1:0] pc
);

   logic [cpu_pkg::data_w-1:0] pc_inc;
   logic [cpu_pkg::data_w-1:0] br_disp;
   logic [cpu_pkg::data_w-1:0] j_disp;
   logic [cpu_pkg::data_w-1:0] disp;
   logic [cpu_pkg::data_w-1:0] target;
   logic                       taken;
   logic [cpu_pkg::data_w-1:0] next_pc;

   assign pc_inc = pc + cpu_pkg::data_w'(2);

   // Signed displacements, sign-extended by assignment
   assign br_disp = $signed(instr[isa_pkg::imm8_msb:isa_pkg::imm8_lsb]);
   assign j_disp  = $signed(instr[isa_pkg::imm11_msb:isa_pkg::imm11_lsb]);

   // Jumps carry the long field, branches the short one
   assign disp = (branch == cpu_pkg::br_jump) ? j_disp : br_disp;

   // Word displacement, relative to PC+2
   assign target = pc_inc + {disp[cpu_pkg::data_w-2:0], 1'b0};

   // Zero flag reflects Rs passed through the ALU
   always_comb begin
      unique case (branch)
         cpu_pkg::br_beqz: taken = zero;
         cpu_pkg::br_bnez: taken = !zero;
         cpu_pkg::br_jump: taken = 1'b1;
         default:          taken = 1'b0;
      endcase
   end

   always_comb begin
      if (hold) begin
         next_pc = pc;
      end else if (taken) begin
         next_pc = target;
      end else begin
         next_pc = pc_inc;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= '0;
      end else begin
         pc <= next_pc;
      end
   end

endmodule

`default_nettype wire

/* source/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_file (
   input  wire logic                       clk,
   input  wire logic                       rst,
   // Read ports
   input  wire cpu_pkg::reg_idx_t          rs1,
   input  wire cpu_pkg::reg_idx_t          rs2,
   output logic      [cpu_pkg::data_w-1:0] rd1,
   output logic      [cpu_pkg::data_w-1:0] rd2,
   // Write port
   input  wire cpu_pkg::reg_idx_t          ws,
   input  wire logic [cpu_pkg::data_w-1:0] wd,
   input  wire logic                       we
);

   localparam int n_regs = 2 ** $bits(cpu_pkg::reg_idx_t);

   logic [cpu_pkg::data_w-1:0] regs [n_regs];

   // Combinational reads, no bypass
   // A write shows up on the read ports the cycle after
   assign rd1 = regs[rs1];
   assign rd2 = regs[rs2];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < n_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (we) begin
         regs[ws] <= wd;
      end
   end

endmodule

`default_nettype wire

/* source/instr_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module instr_decode (
   input  wire logic [cpu_pkg::data_w-1:0] instr,
   output cpu_pkg::ctrl_t                  ctrl
);

   isa_pkg::opcode_e opcode;
   logic [1:0]       func;

   assign opcode = isa_pkg::opcode_e'(instr[isa_pkg::opcode_msb:isa_pkg::opcode_lsb]);
   assign func   = instr[isa_pkg::func_msb:isa_pkg::func_lsb];

   always_comb begin
      // Defaults describe a nop
      ctrl.alu_op  = cpu_pkg::alu_add;
      ctrl.dest    = instr[isa_pkg::rd_r_msb:isa_pkg::rd_r_lsb];
      ctrl.reg_we  = 1'b0;
      ctrl.branch  = cpu_pkg::br_none;
      ctrl.halt    = 1'b0;
      ctrl.illegal = 1'b0;

      case (opcode)
         isa_pkg::op_halt: ctrl.halt = 1'b1;
         isa_pkg::op_nop: ;
         // R-format, rd field
         isa_pkg::op_arith: begin
            ctrl.reg_we = 1'b1;
            unique case (func)
               isa_pkg::func_add: ctrl.alu_op = cpu_pkg::alu_add;
               isa_pkg::func_sub: ctrl.alu_op = cpu_pkg::alu_sub;
               isa_pkg::func_xor: ctrl.alu_op = cpu_pkg::alu_xor;
               default:           ctrl.alu_op = cpu_pkg::alu_and;
            endcase
         end
         isa_pkg::op_shift: begin
            ctrl.reg_we = 1'b1;
            unique case (func)
               isa_pkg::func_sll: ctrl.alu_op = cpu_pkg::alu_sll;
               isa_pkg::func_srl: ctrl.alu_op = cpu_pkg::alu_srl;
               isa_pkg::func_rol: ctrl.alu_op = cpu_pkg::alu_rol;
               default:           ctrl.alu_op = cpu_pkg::alu_ror;
            endcase
         end
         // I-format, destination in the rt slot
         isa_pkg::op_addi: begin
            ctrl.dest   = instr[isa_pkg::rd_i_msb:isa_pkg::rd_i_lsb];
            ctrl.reg_we = 1'b1;
         end
         isa_pkg::op_xori: begin
            ctrl.alu_op = cpu_pkg::alu_xor;
            ctrl.dest   = instr[isa_pkg::rd_i_msb:isa_pkg::rd_i_lsb];
            ctrl.reg_we = 1'b1;
         end
         // lbi writes the register named by the rs field
         isa_pkg::op_lbi: begin
            ctrl.alu_op = cpu_pkg::alu_pass_b;
            ctrl.dest   = instr[isa_pkg::rs_msb:isa_pkg::rs_lsb];
            ctrl.reg_we = 1'b1;
         end
         // Rs + 0 through the ALU sets zero for the test
         isa_pkg::op_beqz: ctrl.branch = cpu_pkg::br_beqz;
         isa_pkg::op_bnez: ctrl.branch = cpu_pkg::br_bnez;
         isa_pkg::op_j:    ctrl.branch = cpu_pkg::br_jump;
         default:          ctrl.illegal = 1'b1;
      endcase
   end

endmodule

`default_nettype wire

/* source/alu_operand_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_operand_decode (
   input  wire logic [cpu_pkg::data_w-1:0] instr,
   input  wire logic [cpu_pkg::data_w-1:0] rs_val,
   input  wire logic [cpu_pkg::data_w-1:0] rt_val,
   output logic      [cpu_pkg::data_w-1:0] op_a,
   output logic      [cpu_pkg::data_w-1:0] op_b
);

   isa_pkg::opcode_e           opcode;
   logic [cpu_pkg::data_w-1:0] imm5_sx;
   logic [cpu_pkg::data_w-1:0] imm5_zx;
   logic [cpu_pkg::data_w-1:0] imm8_sx;

   assign opcode = isa_pkg::opcode_e'(instr[isa_pkg::opcode_msb:isa_pkg::opcode_lsb]);

   // Signed fields extend with the sign bit, unsigned with zeros
   assign imm5_sx = $signed(instr[isa_pkg::imm5_msb:isa_pkg::imm5_lsb]);
   assign imm5_zx = instr[isa_pkg::imm5_msb:isa_pkg::imm5_lsb];
   assign imm8_sx = $signed(instr[isa_pkg::imm8_msb:isa_pkg::imm8_lsb]);

   // A is always Rs
   assign op_a = rs_val;

   always_comb begin
      case (opcode)
         isa_pkg::op_arith,
         isa_pkg::op_shift: op_b = rt_val;
         isa_pkg::op_addi:  op_b = imm5_sx;
         isa_pkg::op_xori:  op_b = imm5_zx;
         isa_pkg::op_lbi:   op_b = imm8_sx;
         // Branches and everything else add zero
         default:           op_b = '0;
      endcase
   end

endmodule

`default_nettype wire

/* source/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu (
   input  wire logic [cpu_pkg::data_w-1:0] a,
   input  wire logic [cpu_pkg::data_w-1:0] b,
   input  wire cpu_pkg::alu_op_e           op,
   output logic      [cpu_pkg::data_w-1:0] result,
   output logic                            zero
);

   localparam int dw = cpu_pkg::data_w;

   logic [3:0]      shamt;
   logic [2*dw-1:0] rot_l;
   logic [2*dw-1:0] rot_r;

   // Shift amount from the low bits of B
   assign shamt = b[3:0];

   // Doubled operand, bits shifted out of one copy wrap in from the other
   assign rot_l = {a, a} << shamt;
   assign rot_r = {a, a} >> shamt;

   always_comb begin
      unique case (op)
         cpu_pkg::alu_add: begin
            result = a + b;
         end
         cpu_pkg::alu_sub: begin
            result = a - b;
         end
         cpu_pkg::alu_xor: begin
            result = a ^ b;
         end
         cpu_pkg::alu_and: begin
            result = a & b;
         end
         cpu_pkg::alu_sll: begin
            result = a << shamt;
         end
         // Logical, zero fill
         cpu_pkg::alu_srl: begin
            result = a >> shamt;
         end
         // Upper half after left rotate
         cpu_pkg::alu_rol: begin
            result = rot_l[2*dw-1:dw];
         end
         // Lower half after right rotate
         cpu_pkg::alu_ror: begin
            result = rot_r[dw-1:0];
         end
         cpu_pkg::alu_pass_b: begin
            result = b;
         end
         default: begin
            result = '0;
         end
      endcase
   end

   // Flag on the result, used by beqz and bnez
   assign zero = (result == '0);

endmodule

`default_nettype wire

/* source/proc.sv */
`timescale 1ns/100ps
`default_nettype none

module proc (
   input  wire logic                       clk,
   input  wire logic                       rst,
   // Program load port for use during reset
   input  wire logic                       prog_we,
   input  wire logic [7:0]                 prog_addr,
   input  wire logic [cpu_pkg::data_w-1:0] prog_data,
   // Status
   output cpu_pkg::commit_t                commit,
   output logic                            halted,
   output logic                            err
);

   logic [cpu_pkg::data_w-1:0] pc;
   logic [cpu_pkg::data_w-1:0] instr;
   cpu_pkg::ctrl_t             ctrl;
   logic [cpu_pkg::data_w-1:0] rf_rd1;
   logic [cpu_pkg::data_w-1:0] rf_rd2;
   logic [cpu_pkg::data_w-1:0] alu_a;
   logic [cpu_pkg::data_w-1:0] alu_b;
   logic [cpu_pkg::data_w-1:0] alu_out;
   logic                       alu_zero;
   logic                       stop;
   logic                       rf_we;

   // Halt and illegal both stop the core
   assign stop = ctrl.halt | ctrl.illegal;

   // Fetch
   fetch_unit fetch (
      .clk   (clk),
      .rst   (rst),
      .hold  (halted | stop),
      .branch(ctrl.branch),
      .zero  (alu_zero),
      .instr (instr),
      .pc    (pc)
   );

   // Loads only land while reset is asserted
   instr_mem imem (
      .clk      (clk),
      .addr     (pc),
      .instr    (instr),
      .load_we  (prog_we & rst),
      .load_addr(prog_addr),
      .load_data(prog_data)
   );

   // Decode
   instr_decode dec (
      .instr(instr),
      .ctrl (ctrl)
   );

   // Write back straight from the ALU
   assign rf_we = ctrl.reg_we & !halted;

   reg_file rf (
      .clk(clk),
      .rst(rst),
      .rs1(instr[isa_pkg::rs_msb:isa_pkg::rs_lsb]),
      .rs2(instr[isa_pkg::rt_msb:isa_pkg::rt_lsb]),
      .rd1(rf_rd1),
      .rd2(rf_rd2),
      .ws (ctrl.dest),
      .wd (alu_out),
      .we (rf_we)
   );

   // Execute
   alu_operand_decode aopd (
      .instr (instr),
      .rs_val(rf_rd1),
      .rt_val(rf_rd2),
      .op_a  (alu_a),
      .op_b  (alu_b)
   );

   alu alu_i (
      .a     (alu_a),
      .b     (alu_b),
      .op    (ctrl.alu_op),
      .result(alu_out),
      .zero  (alu_zero)
   );

   // Retire record with dest and data zeroed when nothing is written
   // Nothing retires while reset is held
   assign commit.valid  = !rst & !halted & !stop;
   assign commit.pc     = pc;
   assign commit.reg_we = rf_we;
   assign commit.dest   = rf_we ? ctrl.dest : '0;
   assign commit.data   = rf_we ? alu_out : '0;

   // Sticky status flags that only reset clears
   always_ff @(posedge clk) begin
      if (rst) begin
         halted <= 1'b0;
         err    <= 1'b0;
      end else if (!halted && stop) begin
         halted <= 1'b1;
         err    <= ctrl.illegal;
      end
   end

endmodule

`default_nettype wire

/* dv/proc_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module proc_tb;

   localparam int max_cycles  = 200;
   localparam int idle_cycles = 5;
   localparam int rst_cycles  = 10;

   logic                       clk;
   logic                       rst;
   logic                       prog_we;
   logic [7:0]                 prog_addr;
   logic [cpu_pkg::data_w-1:0] prog_data;
   cpu_pkg::commit_t           commit;
   logic                       halted;
   logic                       err;

   // Trace contents
   logic [7:0]                 load_addr_q[$];
   logic [cpu_pkg::data_w-1:0] load_data_q[$];
   cpu_pkg::commit_t           expect_q[$];
   logic                       expect_err;

   int   value_errors;
   int   other_errors;
   int   commits_seen;
   int   cycles;
   logic opened;

   proc uut (
      .clk      (clk),
      .rst      (rst),
      .prog_we  (prog_we),
      .prog_addr(prog_addr),
      .prog_data(prog_data),
      .commit   (commit),
      .halted   (halted),
      .err      (err)
   );

   // 8 ns period
   always #4 clk = ~clk;

   // Sort P, E and R lines into queues and skip comment lines
   task automatic read_trace(output logic ok);
      int                         fd;
      int                         n;
      string                      line;
      logic [cpu_pkg::data_w-1:0] a;
      logic [cpu_pkg::data_w-1:0] b;
      logic [cpu_pkg::data_w-1:0] c;
      logic [cpu_pkg::data_w-1:0] d;
      cpu_pkg::commit_t           e;
      fd = $fopen("dv/proc_trace.txt", "r");
      ok = (fd != 0);
      if (ok) begin
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0) begin
               if (line.getc(0) == "P") begin
                  n = $sscanf(line, "P %h %h", a, b);
                  load_addr_q.push_back(a[7:0]);
                  load_data_q.push_back(b);
               end else if (line.getc(0) == "E") begin
                  n = $sscanf(line, "E %h %h %h %h", a, b, c, d);
                  e.valid  = 1'b1;
                  e.pc     = a;
                  e.reg_we = b[0];
                  e.dest   = c[2:0];
                  e.data   = d;
                  expect_q.push_back(e);
               end else if (line.getc(0) == "R") begin
                  n = $sscanf(line, "R %h", a);
                  expect_err = a[0];
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // One word per falling edge while the core is in reset
   task automatic load_program();
      for (int i = 0; i < load_addr_q.size(); i++) begin
         @(negedge clk);
         prog_we   = 1'b1;
         prog_addr = load_addr_q[i];
         prog_data = load_data_q[i];
      end
      @(negedge clk);
      prog_we = 1'b0;
   endtask

   // Outputs held at their reset values before the core starts
   task automatic check_reset_state();
      if (commit.valid !== 1'b0 || commit.pc !== '0) begin
         $display("Error at %0t: in reset commit valid %b pc %h, expected 0 and 0000",
                  $time, commit.valid, commit.pc);
         value_errors++;
      end
      if (halted !== 1'b0 || err !== 1'b0) begin
         $display("Error at %0t: in reset halted %b err %b, expected both 0",
                  $time, halted, err);
         value_errors++;
      end
   endtask

   // Commit record against the next expected entry
   task automatic check_commit();
      cpu_pkg::commit_t exp;
      if (commits_seen >= expect_q.size()) begin
         $display("Error at %0t: extra commit at pc %h, only %0d expected",
                  $time, commit.pc, expect_q.size());
         value_errors++;
      end else begin
         exp = expect_q[commits_seen];
         if (commit !== exp) begin
            $display("Error at %0t: commit %0d got pc %h we %b dest %0d data %h",
                     $time, commits_seen, commit.pc, commit.reg_we, commit.dest,
                     commit.data);
            $display("   expected pc %h we %b dest %0d data %h",
                     exp.pc, exp.reg_we, exp.dest, exp.data);
            value_errors++;
         end
      end
      commits_seen++;
   endtask

   // Commits sampled at the rising edge before the state updates
   task automatic run_until_halt();
      cycles = 0;
      while (!halted && cycles < max_cycles) begin
         @(posedge clk);
         if (commit.valid) begin
            check_commit();
         end
         cycles++;
      end
      if (!halted) begin
         $display("Timeout: halted did not rise within %0d cycles", max_cycles);
         other_errors++;
      end
   endtask

   // Stopped core keeps its PC and retires nothing
   task automatic check_stopped();
      logic [cpu_pkg::data_w-1:0] held_pc;
      held_pc = commit.pc;
      for (int i = 0; i < idle_cycles; i++) begin
         if (commit.valid !== 1'b0) begin
            $display("Error at %0t: commit at pc %h after halt", $time, commit.pc);
            value_errors++;
         end
         if (commit.pc !== held_pc) begin
            $display("Error at %0t: pc moved to %h after halt, held at %h",
                     $time, commit.pc, held_pc);
            value_errors++;
         end
         @(negedge clk);
      end
      if (commits_seen != expect_q.size()) begin
         $display("Error at %0t: %0d commits seen, %0d expected",
                  $time, commits_seen, expect_q.size());
         value_errors++;
      end
      if (err !== expect_err) begin
         $display("Error at %0t: err is %b, expected %b", $time, err, expect_err);
         value_errors++;
      end
   endtask

   initial begin
      clk          = 1'b0;
      rst          = 1'b1;
      prog_we      = 1'b0;
      prog_addr    = '0;
      prog_data    = '0;
      expect_err   = 1'bx;
      value_errors = 0;
      other_errors = 0;
      commits_seen = 0;
      read_trace(opened);
      if (!opened) begin
         $display("Could not open the trace file dv/proc_trace.txt");
         other_errors++;
      end else begin
         load_program();
         repeat (rst_cycles) @(negedge clk);
         check_reset_state();
         // First instruction retires at the next rising edge
         rst = 1'b0;
         run_until_halt();
         check_stopped();
      end
      $display("Summary: %0d commits checked, %0d value errors, %0d other errors",
               commits_seen, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* project.f */
source/isa_pkg.sv
source/cpu_pkg.sv
source/instr_mem.sv
source/fetch_unit.sv
source/reg_file.sv
source/instr_decode.sv
source/alu_operand_decode.sv
source/alu.sv
source/proc.sv
dv/proc_tb.sv

/* dv/proc_trace.txt */
# P word_addr instr : program load, hex
# E pc reg_we dest data : expected commit in order, hex ; R err : final error flag
P 00 C105
P 01 C2FD
P 02 D94C
P 03 D951
P 04 D956
P 05 DA9B
P 06 41FC
P 07 52DF
P 08 D194
P 09 D675
P 0A D696
P 0B D177
P 0C 6101
P 0D 6901
P 0E C57F
P 0F 6001
P 10 C57F
P 11 6805
P 12 C102
P 13 C200
P 14 4242
P 15 413F
P 16 6101
P 17 27FC
P 18 F800
P 19 C3AA
# lbi, arith, immediates
E 0000 1 1 0005
E 0002 1 2 FFFD
E 0004 1 3 0002
E 0006 1 4 0008
E 0008 1 5 FFF8
E 000A 1 6 0008
E 000C 1 7 0001
E 000E 1 6 FFE2
# shifts and rotates
E 0010 1 5 0500
E 0012 1 5 3FF8
E 0014 1 5 E2FF
E 0016 1 5 4001
# branches, taken ones skip 001C and 0020
E 0018 0 0 0000
E 001A 0 0 0000
E 001E 0 0 0000
E 0022 0 0 0000
# loop of two passes, exit through beqz
E 0024 1 1 0002
E 0026 1 2 0000
E 0028 1 2 0002
E 002A 1 1 0001
E 002C 0 0 0000
E 002E 0 0 0000
E 0028 1 2 0004
E 002A 1 1 0000
E 002C 0 0 0000
# illegal opcode at 0030 stops the core
R 1
